// File: vec_cache_cfg_pkg.sv
package vec_cache_cfg_pkg;

    // ==================================================
    // line data and data SRAM
    // ==================================================
    localparam int DATA_WIDTH = 128;
    localparam int LINE_NUM   = 32;

    typedef logic [DATA_WIDTH-1:0]       data_t;
    typedef logic [$clog2(LINE_NUM)-1:0] line_idx_t;

    // fixed read latency of the data SRAM in cycles
    localparam int READ_SRAM_DELAY = 4;

    // ==================================================
    // read data buffer
    // ==================================================
    localparam int RW_DB_ENTRY_NUM   = 8;
    localparam int DB_BANK_ENTRY_NUM = 4;
    // ping-pong pair of banks
    localparam int DB_BANK_NUM       = RW_DB_ENTRY_NUM / DB_BANK_ENTRY_NUM;

    typedef logic [$clog2(DB_BANK_ENTRY_NUM)-1:0] db_entry_id_t;
    typedef logic [DB_BANK_ENTRY_NUM-1:0]         db_mask_t;

    // in-order queue pointer, one slot per buffer entry
    typedef logic [$clog2(RW_DB_ENTRY_NUM)-1:0]   q_ptr_t;
    // 0..RW_DB_ENTRY_NUM plus headroom for reservations
    typedef logic [$clog2(RW_DB_ENTRY_NUM):0]     credit_cnt_t;

    // ==================================================
    // request tags
    // ==================================================
    typedef logic [3:0] rob_entry_id_t;
    typedef logic [5:0] txn_id_t;
    typedef logic [3:0] sideband_t;

endpackage

// File: vec_cache_msg_pkg.sv
package vec_cache_msg_pkg;

    // ==================================================
    // arbiter side
    // ==================================================
    // one read request as granted by the arbiter
    typedef struct packed {
        vec_cache_cfg_pkg::line_idx_t     line_idx;
        vec_cache_cfg_pkg::rob_entry_id_t rob_entry_id;
        vec_cache_cfg_pkg::txn_id_t       txn_id;
        vec_cache_cfg_pkg::sideband_t     sideband;
    } arb_out_req_t;

    // ==================================================
    // data SRAM to buffer agent
    // ==================================================
    // request fields travel with the line
    typedef struct packed {
        arb_out_req_t                     req;
        vec_cache_cfg_pkg::data_t         data;
    } ram_rsp_t;

    // one filled buffer entry, queued in arrival order
    typedef struct packed {
        logic                             bank;
        vec_cache_cfg_pkg::db_entry_id_t  db_entry_id;
        vec_cache_cfg_pkg::rob_entry_id_t rob_entry_id;
        vec_cache_cfg_pkg::txn_id_t       txn_id;
        vec_cache_cfg_pkg::sideband_t     sideband;
    } rw_rdb_pld_t;

    // ==================================================
    // upstream
    // ==================================================
    typedef struct packed {
        vec_cache_cfg_pkg::data_t         data;
        vec_cache_cfg_pkg::txn_id_t       txn_id;
        vec_cache_cfg_pkg::rob_entry_id_t rob_entry_id;
        vec_cache_cfg_pkg::sideband_t     sideband;
    } us_data_pld_t;

endpackage

// File: vec_cache_pre_alloc.sv
`timescale 1ns/1ps

module vec_cache_pre_alloc (
    input  logic                            clk,
    input  logic                            rst_n,
    input  vec_cache_cfg_pkg::db_mask_t     idle,
    input  logic                            take,
    output logic                            out_vld,
    output vec_cache_cfg_pkg::db_entry_id_t out_index
);

    vec_cache_cfg_pkg::db_mask_t     cand;
    logic                            pick_vld;
    vec_cache_cfg_pkg::db_entry_id_t pick_idx;

    // the reserved entry is still marked idle on the take cycle
    always_comb begin
        cand = idle;
        if (take) begin
            cand[out_index] = 1'b0;
        end
    end

    // lowest idle index wins
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = '0;
        for (int i = vec_cache_cfg_pkg::DB_BANK_ENTRY_NUM - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick_vld = 1'b1;
                pick_idx = vec_cache_cfg_pkg::db_entry_id_t'(i);
            end
        end
    end

    // registered one step ahead so the write side never waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld   <= 1'b0;
            out_index <= '0;
        end else begin
            out_vld   <= pick_vld;
            out_index <= pick_idx;
        end
    end

endmodule

// File: vec_cache_rdb_mem.sv
`timescale 1ns/1ps

module vec_cache_rdb_mem (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            wr_en,
    input  vec_cache_cfg_pkg::db_entry_id_t addr,
    input  vec_cache_cfg_pkg::data_t        wr_data,
    output vec_cache_cfg_pkg::data_t        rd_data
);

    vec_cache_cfg_pkg::data_t mem [vec_cache_cfg_pkg::DB_BANK_ENTRY_NUM];

    // single port, write or registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end else begin
                rd_data <= mem[addr];
            end
        end
    end

endmodule

// File: vec_cache_data_ram.sv
`timescale 1ns/1ps

module vec_cache_data_ram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            fill_vld,
    input  vec_cache_cfg_pkg::line_idx_t    fill_idx,
    input  vec_cache_cfg_pkg::data_t        fill_data,
    input  logic                            req_vld,
    input  vec_cache_msg_pkg::arb_out_req_t req,
    output logic                            rsp_vld,
    output vec_cache_msg_pkg::ram_rsp_t     rsp
);

    vec_cache_cfg_pkg::data_t              line_mem [vec_cache_cfg_pkg::LINE_NUM];
    logic [vec_cache_cfg_pkg::READ_SRAM_DELAY-1:0] stg_vld;
    vec_cache_msg_pkg::ram_rsp_t           stg_pld [vec_cache_cfg_pkg::READ_SRAM_DELAY];

    // ==================================================
    // line array
    // ==================================================
    // fill wins nothing over a same-edge read, the read sees the old line
    always_ff @(posedge clk) begin
        if (fill_vld) begin
            line_mem[fill_idx] <= fill_data;
        end
    end

    // ==================================================
    // read pipeline
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_vld <= '0;
        end else begin
            stg_vld <= {stg_vld[vec_cache_cfg_pkg::READ_SRAM_DELAY-2:0], req_vld};
        end
    end

    // line is read at acceptance, then carried with its request
    always_ff @(posedge clk) begin
        if (req_vld) begin
            stg_pld[0].req  <= req;
            stg_pld[0].data <= line_mem[req.line_idx];
        end
        for (int i = 1; i < vec_cache_cfg_pkg::READ_SRAM_DELAY; i++) begin
            if (stg_vld[i-1]) begin
                stg_pld[i] <= stg_pld[i-1];
            end
        end
    end

    assign rsp_vld = stg_vld[vec_cache_cfg_pkg::READ_SRAM_DELAY-1];
    assign rsp     = stg_pld[vec_cache_cfg_pkg::READ_SRAM_DELAY-1];

endmodule

// File: vec_cache_rdb_agent.sv
`timescale 1ns/1ps

module vec_cache_rdb_agent (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rsp_vld,
    input  vec_cache_msg_pkg::ram_rsp_t      rsp,
    output logic                             rd_rdy,
    input  logic                             us_rdy,
    output logic                             us_data_vld,
    output vec_cache_msg_pkg::us_data_pld_t  us_data,
    output logic                             done,
    output vec_cache_cfg_pkg::rob_entry_id_t done_idx
);

    // write side
    logic                            bank_sel;
    logic [vec_cache_cfg_pkg::DB_BANK_NUM-1:0] alloc_vld;
    vec_cache_cfg_pkg::db_entry_id_t alloc_idx [vec_cache_cfg_pkg::DB_BANK_NUM];
    vec_cache_cfg_pkg::data_t        bank_rd_data [vec_cache_cfg_pkg::DB_BANK_NUM];
    vec_cache_msg_pkg::rw_rdb_pld_t  wr_pld;

    // in-order queue
    vec_cache_msg_pkg::rw_rdb_pld_t  q_mem [vec_cache_cfg_pkg::RW_DB_ENTRY_NUM];
    vec_cache_cfg_pkg::q_ptr_t       q_wr_ptr;
    vec_cache_cfg_pkg::q_ptr_t       q_rd_ptr;
    vec_cache_cfg_pkg::credit_cnt_t  q_cnt;
    vec_cache_cfg_pkg::credit_cnt_t  q_cnt_nxt;
    vec_cache_msg_pkg::rw_rdb_pld_t  q_head;

    // read side
    logic                            grant;
    vec_cache_msg_pkg::rw_rdb_pld_t  out_pld_q;

    // admission credit
    logic [vec_cache_cfg_pkg::READ_SRAM_DELAY-2:0] rdy_hist;
    logic [vec_cache_cfg_pkg::READ_SRAM_DELAY-1:0] rdy_hist_nxt;
    vec_cache_cfg_pkg::credit_cnt_t  est_cnt;

    // ==================================================
    // write side
    // ==================================================
    always_comb begin
        wr_pld.bank         = bank_sel;
        wr_pld.db_entry_id  = alloc_idx[bank_sel];
        wr_pld.rob_entry_id = rsp.req.rob_entry_id;
        wr_pld.txn_id       = rsp.req.txn_id;
        wr_pld.sideband     = rsp.req.sideband;
    end

    assign q_head = q_mem[q_rd_ptr];

    // writes own the bank cycle, so a read only goes when no line lands
    assign grant = (q_cnt != '0) && us_rdy && !rsp_vld;

    for (genvar b = 0; b < vec_cache_cfg_pkg::DB_BANK_NUM; b++) begin : g_bank
        vec_cache_cfg_pkg::db_mask_t     idle;
        logic                            take;
        logic                            rd_hit;
        logic                            mem_en;
        vec_cache_cfg_pkg::db_entry_id_t mem_addr;

        assign take     = rsp_vld && (bank_sel == 1'(b)) && alloc_vld[b];
        assign rd_hit   = grant && (q_head.bank == 1'(b));
        assign mem_en   = take || rd_hit;
        assign mem_addr = take ? alloc_idx[b] : q_head.db_entry_id;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                idle <= '1;
            end else begin
                if (take) begin
                    idle[alloc_idx[b]] <= 1'b0;
                end
                if (rd_hit) begin
                    idle[q_head.db_entry_id] <= 1'b1;
                end
            end
        end

        vec_cache_pre_alloc u_pre_alloc (
            .clk       (clk),
            .rst_n     (rst_n),
            .idle      (idle),
            .take      (take),
            .out_vld   (alloc_vld[b]),
            .out_index (alloc_idx[b])
        );

        vec_cache_rdb_mem u_rdb_mem (
            .clk     (clk),
            .en      (mem_en),
            .wr_en   (take),
            .addr    (mem_addr),
            .wr_data (rsp.data),
            .rd_data (bank_rd_data[b])
        );
    end

    // ==================================================
    // queue and credit
    // ==================================================
    always_ff @(posedge clk) begin
        if (rsp_vld) begin
            q_mem[q_wr_ptr] <= wr_pld;
        end
    end

    always_comb begin
        q_cnt_nxt = q_cnt;
        if (rsp_vld) begin
            q_cnt_nxt = q_cnt_nxt + 1'b1;
        end
        if (grant) begin
            q_cnt_nxt = q_cnt_nxt - 1'b1;
        end
    end

    // a ready cycle holds a slot until its line could have landed
    assign rdy_hist_nxt = {rdy_hist, rd_rdy};

    always_comb begin
        est_cnt = q_cnt_nxt;
        for (int i = 0; i < vec_cache_cfg_pkg::READ_SRAM_DELAY; i++) begin
            est_cnt = est_cnt + rdy_hist_nxt[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
            bank_sel <= 1'b0;
            rdy_hist <= '0;
            rd_rdy   <= 1'b0;
        end else begin
            if (rsp_vld) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
                bank_sel <= ~bank_sel;
            end
            if (grant) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_cnt    <= q_cnt_nxt;
            rdy_hist <= rdy_hist_nxt[vec_cache_cfg_pkg::READ_SRAM_DELAY-2:0];
            // counts the accept that may land on this edge as well
            rd_rdy   <= (est_cnt < vec_cache_cfg_pkg::RW_DB_ENTRY_NUM);
        end
    end

    // ==================================================
    // upstream
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            us_data_vld <= 1'b0;
        end else begin
            us_data_vld <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out_pld_q <= q_head;
        end
    end

    // bank read data lines up with the delayed entry
    assign us_data.data         = bank_rd_data[out_pld_q.bank];
    assign us_data.txn_id       = out_pld_q.txn_id;
    assign us_data.rob_entry_id = out_pld_q.rob_entry_id;
    assign us_data.sideband     = out_pld_q.sideband;

    // rob release goes with the beat
    assign done     = us_data_vld;
    assign done_idx = out_pld_q.rob_entry_id;

endmodule

// File: vec_cache_rd_path_top.sv
`timescale 1ns/1ps

module vec_cache_rd_path_top (
    input  logic                             clk,
    input  logic                             rst_n,
    // fill port
    input  logic                             fill_vld,
    input  vec_cache_cfg_pkg::line_idx_t     fill_idx,
    input  vec_cache_cfg_pkg::data_t         fill_data,
    // arbiter requests
    input  logic                             rd_vld,
    input  vec_cache_msg_pkg::arb_out_req_t  rd_req,
    output logic                             rd_rdy,
    // upstream
    input  logic                             us_rdy,
    output logic                             us_data_vld,
    output vec_cache_msg_pkg::us_data_pld_t  us_data,
    output logic                             done,
    output vec_cache_cfg_pkg::rob_entry_id_t done_idx
);

    logic                        req_vld;
    logic                        rsp_vld;
    vec_cache_msg_pkg::ram_rsp_t rsp;

    // accepted request only
    assign req_vld = rd_vld && rd_rdy;

    // ==================================================
    // data SRAM stage
    // ==================================================
    vec_cache_data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .fill_vld  (fill_vld),
        .fill_idx  (fill_idx),
        .fill_data (fill_data),
        .req_vld   (req_vld),
        .req       (rd_req),
        .rsp_vld   (rsp_vld),
        .rsp       (rsp)
    );

    // ==================================================
    // buffer agent stage
    // ==================================================
    vec_cache_rdb_agent u_rdb_agent (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp_vld     (rsp_vld),
        .rsp         (rsp),
        .rd_rdy      (rd_rdy),
        .us_rdy      (us_rdy),
        .us_data_vld (us_data_vld),
        .us_data     (us_data),
        .done        (done),
        .done_idx    (done_idx)
    );

endmodule

// File: tb_vec_cache_rd_path.sv
`timescale 1ns/1ps

module tb_vec_cache_rd_path;

    typedef struct packed {
        logic [2:0]                       test;
        vec_cache_cfg_pkg::line_idx_t     line;
        vec_cache_cfg_pkg::rob_entry_id_t rob;
        vec_cache_cfg_pkg::txn_id_t       txn;
        vec_cache_cfg_pkg::sideband_t     sb;
        logic [3:0]                       gap;
        logic [7:0]                       hold;
    } stim_t;

    typedef struct packed {
        vec_cache_cfg_pkg::data_t         data;
        vec_cache_cfg_pkg::txn_id_t       txn;
        vec_cache_cfg_pkg::rob_entry_id_t rob;
        vec_cache_cfg_pkg::sideband_t     sb;
        logic                             chk_lat;
        logic [31:0]                      acc_cyc;
    } exp_beat_t;

    logic                             clk;
    logic                             rst_n;
    logic                             fill_vld;
    vec_cache_cfg_pkg::line_idx_t     fill_idx;
    vec_cache_cfg_pkg::data_t         fill_data;
    logic                             rd_vld;
    vec_cache_msg_pkg::arb_out_req_t  rd_req;
    logic                             rd_rdy;
    logic                             us_rdy;
    logic                             us_data_vld;
    vec_cache_msg_pkg::us_data_pld_t  us_data;
    logic                             done;
    vec_cache_cfg_pkg::rob_entry_id_t done_idx;

    vec_cache_cfg_pkg::data_t ref_mem [vec_cache_cfg_pkg::LINE_NUM];
    stim_t                    stim_tab [$];
    exp_beat_t                exp_q [$];
    logic [31:0]              rng_state = 32'h3a75_0cf6;
    int cyc = 0;
    int err_cnt = 0;
    int check_cnt = 0;
    int test_cnt = 0;
    int acc_cnt = 0;
    int beat_cnt = 0;
    int done_cnt = 0;
    int hold_left = 0;
    logic lat_check = 1'b0;
    logic saw_rdy_low = 1'b0;
    logic us_rdy_prev = 1'b0;

    vec_cache_rd_path_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_vld    (fill_vld),
        .fill_idx    (fill_idx),
        .fill_data   (fill_data),
        .rd_vld      (rd_vld),
        .rd_req      (rd_req),
        .rd_rdy      (rd_rdy),
        .us_rdy      (us_rdy),
        .us_data_vld (us_data_vld),
        .us_data     (us_data),
        .done        (done),
        .done_idx    (done_idx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_line_data(output vec_cache_cfg_pkg::data_t d);
        for (int w = 0; w < vec_cache_cfg_pkg::DATA_WIDTH / 32; w++) begin
            rng_state = xorshift32(rng_state);
            d[w*32 +: 32] = rng_state;
        end
    endtask

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Some tests failed");
        $finish;
    endtask

    // one clock step, inputs move 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (hold_left > 0) begin
            hold_left--;
        end
        us_rdy = (hold_left == 0);
    endtask

    task automatic fill_line(input int idx, input vec_cache_cfg_pkg::data_t d);
        fill_vld  = 1'b1;
        fill_idx  = vec_cache_cfg_pkg::line_idx_t'(idx);
        fill_data = d;
        ref_mem[idx] = d;
        next_cycle();
        fill_vld = 1'b0;
    endtask

    task automatic add_stim(input int test, input int line, input int rob, input int txn,
                            input int sb, input int gap, input int hold);
        stim_t s;
        s.test = 3'(test);
        s.line = vec_cache_cfg_pkg::line_idx_t'(line);
        s.rob  = vec_cache_cfg_pkg::rob_entry_id_t'(rob);
        s.txn  = vec_cache_cfg_pkg::txn_id_t'(txn);
        s.sb   = vec_cache_cfg_pkg::sideband_t'(sb);
        s.gap  = 4'(gap);
        s.hold = 8'(hold);
        stim_tab.push_back(s);
    endtask

    // present one request and hold it until rd_rdy takes it
    task automatic send_req(input stim_t s);
        int t;
        t = 0;
        if (s.hold != 0) begin
            hold_left = s.hold;
            us_rdy    = 1'b0;
        end
        rd_vld              = 1'b1;
        rd_req.line_idx     = s.line;
        rd_req.rob_entry_id = s.rob;
        rd_req.txn_id       = s.txn;
        rd_req.sideband     = s.sb;
        @(negedge clk);
        while (!rd_rdy) begin
            t++;
            if (t > 200) begin
                abort_run("rd_rdy stayed low, request never accepted");
            end
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        rd_vld = 1'b0;
        repeat (s.gap) next_cycle();
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 || hold_left != 0) begin
            t++;
            if (t > 300) begin
                abort_run("expected beats never arrived on the upstream port");
            end
            next_cycle();
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "single_latency";
            3: return "back_to_back";
            4: return "done_release";
            5: return "back_pressure";
            default: return "refill";
        endcase
    endfunction

    task automatic report_test(input int id, input int err0);
        test_cnt++;
        $display("test %0d %-15s %s", id, test_name(id), (err_cnt == err0) ? "ok" : "FAILED");
    endtask

    // ==================================================
    // monitor and scoreboard
    // ==================================================
    always @(negedge clk) begin
        exp_beat_t e;
        if (rst_n) begin
            if (us_data_vld || done) begin
                check_eq(done, us_data_vld, "done with beat");
            end
            if (us_data_vld) begin
                beat_cnt++;
                check_eq(us_rdy_prev, 1'b1, "beat after us_rdy low");
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("unexpected beat at %0t with no request outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_eq(us_data.data, e.data, "data");
                    check_eq(us_data.txn_id, e.txn, "txn_id");
                    check_eq(us_data.rob_entry_id, e.rob, "rob_entry_id");
                    check_eq(us_data.sideband, e.sb, "sideband");
                    check_eq(done_idx, e.rob, "done_idx");
                    if (e.chk_lat) begin
                        check_eq(cyc - e.acc_cyc, vec_cache_cfg_pkg::READ_SRAM_DELAY + 2,
                                 "latency");
                    end
                end
            end
            if (done) begin
                done_cnt++;
            end
            if (!rd_rdy) begin
                saw_rdy_low = 1'b1;
            end
            // accepted on the coming edge
            if (rd_vld && rd_rdy) begin
                e.data    = ref_mem[rd_req.line_idx];
                e.txn     = rd_req.txn_id;
                e.rob     = rd_req.rob_entry_id;
                e.sb      = rd_req.sideband;
                e.chk_lat = lat_check;
                e.acc_cyc = cyc;
                exp_q.push_back(e);
                acc_cnt++;
            end
            check_eq((acc_cnt - beat_cnt) <= vec_cache_cfg_pkg::RW_DB_ENTRY_NUM, 1'b1,
                     "outstanding limit");
        end
        us_rdy_prev = us_rdy;
    end

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        vec_cache_cfg_pkg::data_t d;
        int err0;
        int beats0;
        int done0;
        int n;
        int t;
        rst_n     = 1'b0;
        fill_vld  = 1'b0;
        fill_idx  = '0;
        fill_data = '0;
        rd_vld    = 1'b0;
        rd_req    = '0;
        us_rdy    = 1'b1;

        add_stim(2, 5, 3, 'h2a, 'h9, 0, 0);
        // mixed lines back to back, both banks
        add_stim(3, 0, 0, 'h01, 'h1, 0, 0);
        add_stim(3, 31, 1, 'h02, 'h2, 0, 0);
        add_stim(3, 12, 2, 'h03, 'h3, 0, 0);
        add_stim(3, 12, 3, 'h04, 'h4, 0, 0);
        add_stim(3, 7, 4, 'h05, 'h5, 0, 0);
        add_stim(3, 18, 5, 'h06, 'h6, 0, 0);
        add_stim(4, 3, 8, 'h11, 'ha, 2, 0);
        add_stim(4, 9, 9, 'h12, 'hb, 0, 0);
        add_stim(4, 27, 10, 'h13, 'hc, 3, 0);
        add_stim(4, 14, 11, 'h14, 'hd, 1, 0);
        // upstream stalled long enough to fill the buffer
        add_stim(5, 1, 12, 'h20, 'h0, 0, 40);
        for (int i = 1; i < 10; i++) begin
            add_stim(5, (i * 3 + 1) % 32, (12 + i) % 16, 'h20 + i, i, 0, 0);
        end
        add_stim(6, 7, 6, 'h3e, 'he, 0, 0);
        add_stim(6, 20, 7, 'h3f, 'hf, 0, 0);

        err0 = err_cnt;
        repeat (16) @(posedge clk);
        #1;
        check_eq(us_data_vld, 1'b0, "us_data_vld in reset");
        check_eq(done, 1'b0, "done in reset");
        check_eq(rd_rdy, 1'b0, "rd_rdy in reset");
        rst_n = 1'b1;
        t = 0;
        while (!rd_rdy) begin
            t++;
            if (t > 2) begin
                abort_run("rd_rdy did not rise within two cycles of reset release");
            end
            next_cycle();
        end
        report_test(1, err0);

        for (int i = 0; i < vec_cache_cfg_pkg::LINE_NUM; i++) begin
            next_line_data(d);
            fill_line(i, d);
        end

        for (int i = 0; i < stim_tab.size(); i++) begin
            if (i == 0 || stim_tab[i].test != stim_tab[i-1].test) begin
                err0   = err_cnt;
                beats0 = beat_cnt;
                done0  = done_cnt;
                n      = 0;
                foreach (stim_tab[j]) begin
                    if (stim_tab[j].test == stim_tab[i].test) begin
                        n++;
                    end
                end
                lat_check   = (stim_tab[i].test == 2);
                saw_rdy_low = 1'b0;
                if (stim_tab[i].test == 6) begin
                    next_line_data(d);
                    fill_line(7, d);
                    next_line_data(d);
                    fill_line(20, d);
                end
            end
            send_req(stim_tab[i]);
            if (i == stim_tab.size() - 1 || stim_tab[i+1].test != stim_tab[i].test) begin
                wait_drain();
                check_eq(beat_cnt - beats0, n, "beat count");
                if (stim_tab[i].test == 4) begin
                    check_eq(done_cnt - done0, n, "done pulses");
                end
                if (stim_tab[i].test == 5) begin
                    check_eq(saw_rdy_low, 1'b1, "rd_rdy drop when full");
                end
                report_test(stim_tab[i].test, err0);
            end
        end

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
vec_cache_cfg_pkg.sv
vec_cache_msg_pkg.sv
vec_cache_pre_alloc.sv
vec_cache_rdb_mem.sv
vec_cache_data_ram.sv
vec_cache_rdb_agent.sv
vec_cache_rd_path_top.sv
tb_vec_cache_rd_path.sv

// File: Bender.yml
package:
  name: vec_cache_rd_path

sources:
  - vec_cache_cfg_pkg.sv
  - vec_cache_msg_pkg.sv
  - vec_cache_pre_alloc.sv
  - vec_cache_rdb_mem.sv
  - vec_cache_data_ram.sv
  - vec_cache_rdb_agent.sv
  - vec_cache_rd_path_top.sv
  - target: simulation
    files:
      - tb_vec_cache_rd_path.sv
